// ==== Bender.yml ====
package:
  name: phy_iface

sources:
  - hdl/phy_mgmt_pkg.sv
  - hdl/mdio_master.sv
  - hdl/rx_capture.sv
  - hdl/phy_reg_slave.sv
  - hdl/phy_iface_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/phy_iface_chk.sv
      - verif/phy_iface_tb.sv

// ==== hdl/mdio_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module mdio_master #(
    parameter int MDC_HALF = 8                          // MDC half period in clocks, 2 or more
) (
    input  logic                        RxClk,
    input  logic                        rst,
    input  logic                        cmd_start,      // One-cycle start request
    input  phy_mgmt_pkg::mdio_cmd_t     cmd_word,
    input  logic                        mdio_in,        // Line level seen at the pin
    output logic                        mdio_out,
    output logic                        mdio_oe,
    output logic                        mdc,
    output logic                        busy,
    output phy_mgmt_pkg::mdio_data_t    rd_data,
    output phy_mgmt_pkg::phy_reg_addr_t rd_reg
);

    localparam int PH_W = $clog2(2 * MDC_HALF);

    localparam logic [PH_W-1:0] PH_DRIVE = PH_W'(1);                 // Just after MDC falls
    localparam logic [PH_W-1:0] PH_RISE  = PH_W'(MDC_HALF - 1);      // MDC rises at next edge
    localparam logic [PH_W-1:0] PH_LAST  = PH_W'(2 * MDC_HALF - 1);  // MDC falls at next edge

    // Bit positions inside the 32-bit command half of the frame
    localparam logic [4:0] RD_CMD_LAST = 5'(30 - phy_mgmt_pkg::TA_MSB);  // Last REGAD bit
    localparam logic [4:0] TA_LAST     = 5'(32 - phy_mgmt_pkg::TA_MSB);  // Second TA bit
    localparam logic [4:0] BIT_LAST    = 5'd31;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_TURNAROUND,
        ST_READ
    } mdio_state_t;

    mdio_state_t             state;
    logic [PH_W-1:0]         phase;     // Position inside one MDC period
    logic [4:0]              bit_cnt;   // Bit within preamble or command half
    logic                    rd_op;     // Current frame is a read
    logic                    bit_end;
    phy_mgmt_pkg::mdio_cmd_t tx_shift;  // Command bits, MSB goes out first

    assign bit_end = (phase == PH_LAST);
    assign busy    = (state != ST_IDLE);

    // ------------------------------------------------------------
    // MDC divider and bit counter
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst || state == ST_IDLE) begin
            phase   <= '0;
            bit_cnt <= '0;
            mdc     <= 1'b0;
        end else begin
            phase <= bit_end ? '0 : phase + PH_W'(1);
            if (bit_end)
                bit_cnt <= bit_cnt + 5'd1;       // Wraps to 0 after the preamble
            if (phase == PH_RISE)
                mdc <= 1'b1;
            else if (bit_end)
                mdc <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Frame sequencer
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            state    <= ST_IDLE;
            rd_op    <= 1'b0;
            mdio_out <= 1'b0;
            mdio_oe  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_start) begin                 // Ignored while busy
                        state    <= ST_PREAMBLE;
                        rd_op    <= (cmd_word[phy_mgmt_pkg::OP_LSB +: 2] == phy_mgmt_pkg::OP_READ);
                        mdio_out <= 1'b1;                // Preamble of ones
                        mdio_oe  <= 1'b1;
                    end
                end
                ST_PREAMBLE: begin
                    if (bit_end && bit_cnt == BIT_LAST)
                        state <= ST_DATA;
                end
                ST_DATA: begin
                    if (phase == PH_DRIVE)
                        mdio_out <= tx_shift[31];        // New bit after MDC falls
                    if (bit_end && rd_op && bit_cnt == RD_CMD_LAST) begin
                        state    <= ST_TURNAROUND;       // PHY owns the line from here
                        mdio_out <= 1'b0;
                        mdio_oe  <= 1'b0;
                    end else if (bit_end && bit_cnt == BIT_LAST) begin
                        state    <= ST_IDLE;
                        mdio_out <= 1'b0;
                        mdio_oe  <= 1'b0;
                    end
                end
                ST_TURNAROUND: begin
                    if (bit_end && bit_cnt == TA_LAST)
                        state <= ST_READ;
                end
                ST_READ: begin
                    if (bit_end && bit_cnt == BIT_LAST)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command shifter, loaded on the accepted start
    always_ff @(posedge RxClk) begin
        if (state == ST_IDLE && cmd_start)
            tx_shift <= cmd_word;
        else if (state == ST_DATA && phase == PH_DRIVE)
            tx_shift <= {tx_shift[30:0], 1'b0};
    end

    // ------------------------------------------------------------
    // Read data capture
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            rd_data <= '0;
            rd_reg  <= '0;
        end else begin
            if (state == ST_IDLE && cmd_start &&
                cmd_word[phy_mgmt_pkg::OP_LSB +: 2] == phy_mgmt_pkg::OP_READ)
                rd_reg <= cmd_word[phy_mgmt_pkg::REGAD_LSB +: 5];
            if (state == ST_READ && phase == PH_RISE)
                rd_data <= {rd_data[14:0], mdio_in};  // Sampled before MDC rises
        end
    end

endmodule

`default_nettype wire

// ==== hdl/phy_iface_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module phy_iface_top #(
    parameter int MDC_HALF = 8,                 // MDC half period in clocks
    parameter int RX_DEPTH = 64                 // Capture buffer bytes
) (
    input  logic                     RxClk,
    input  logic                     rst,
    // Wishbone classic slave port
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  phy_mgmt_pkg::wb_addr_t   wb_adr,
    input  phy_mgmt_pkg::wb_data_t   wb_dat_w,
    output phy_mgmt_pkg::wb_data_t   wb_dat_r,
    output logic                     wb_ack,
    // PHY pins
    output logic                     mdc,
    inout  wire                      mdio,
    output logic                     phy_rst_n,
    input  logic                     rx_valid,
    input  phy_mgmt_pkg::rx_nibble_t rx_data
);

    localparam int AW = $clog2(RX_DEPTH);

    logic                        cmd_start;
    phy_mgmt_pkg::mdio_cmd_t     cmd_word;
    logic                        busy;
    phy_mgmt_pkg::mdio_data_t    rd_data;
    phy_mgmt_pkg::phy_reg_addr_t rd_reg;
    logic                        mdio_out;
    logic                        mdio_oe;
    logic                        cap_restart;
    logic [AW-1:0]               buf_addr;
    phy_mgmt_pkg::rx_byte_t      buf_byte;
    logic [AW-1:0]               cap_count;

    // ------------------------------------------------------------
    // Pins
    // ------------------------------------------------------------
    assign mdio      = mdio_oe ? mdio_out : 1'bz;  // Released when not driving
    assign phy_rst_n = 1'b1;                       // PHY never held in reset

    phy_reg_slave #(
        .RX_DEPTH (RX_DEPTH)
    ) phy_reg_slave_inst (
        .RxClk       (RxClk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .cmd_start   (cmd_start),
        .cmd_word    (cmd_word),
        .busy        (busy),
        .rd_data     (rd_data),
        .rd_reg      (rd_reg),
        .cap_restart (cap_restart),
        .buf_addr    (buf_addr),
        .buf_byte    (buf_byte),
        .cap_count   (cap_count)
    );

    mdio_master #(
        .MDC_HALF (MDC_HALF)
    ) mdio_master_inst (
        .RxClk     (RxClk),
        .rst       (rst),
        .cmd_start (cmd_start),
        .cmd_word  (cmd_word),
        .mdio_in   (mdio),          // Pin level, own drive included
        .mdio_out  (mdio_out),
        .mdio_oe   (mdio_oe),
        .mdc       (mdc),
        .busy      (busy),
        .rd_data   (rd_data),
        .rd_reg    (rd_reg)
    );

    rx_capture #(
        .RX_DEPTH (RX_DEPTH)
    ) rx_capture_inst (
        .RxClk       (RxClk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .cap_restart (cap_restart),
        .buf_addr    (buf_addr),
        .buf_byte    (buf_byte),
        .cap_count   (cap_count)
    );

endmodule

`default_nettype wire

// ==== hdl/phy_mgmt_pkg.sv ====
`default_nettype none

package phy_mgmt_pkg;

    // ------------------------------------------------------------
    // Vector types with a meaning of their own
    // ------------------------------------------------------------
    typedef logic [7:0]  wb_addr_t;       // Wishbone word address
    typedef logic [31:0] wb_data_t;       // Wishbone data word
    typedef logic [31:0] mdio_cmd_t;      // ST OP PHYAD REGAD TA DATA, sent from bit 31
    typedef logic [15:0] mdio_data_t;     // PHY register value
    typedef logic [4:0]  phy_reg_addr_t;  // Clause 22 register address
    typedef logic [7:0]  rx_byte_t;       // Captured receive byte
    typedef logic [3:0]  rx_nibble_t;     // MII receive nibble

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    // Addresses with bit 7 clear read the capture buffer
    localparam wb_addr_t ADDR_MDIO_CMD   = 8'h80;  // Write starts a frame, read gives status
    localparam wb_addr_t ADDR_RX_RESTART = 8'h81;  // Write restarts capture, read gives count

    // ------------------------------------------------------------
    // Command word fields
    // ------------------------------------------------------------
    localparam logic [1:0] OP_READ = 2'b10;   // Clause 22 read opcode

    localparam int OP_LSB    = 28;            // OP in bits 29:28
    localparam int REGAD_LSB = 18;            // REGAD in bits 22:18
    localparam int TA_MSB    = 17;            // TA in bits 17:16, data below

endpackage

`default_nettype wire

// ==== hdl/phy_reg_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module phy_reg_slave #(
    parameter int RX_DEPTH = 64                       // Capture buffer size, 128 at most
) (
    input  logic                        RxClk,
    input  logic                        rst,
    // Wishbone classic slave
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  phy_mgmt_pkg::wb_addr_t      wb_adr,
    input  phy_mgmt_pkg::wb_data_t      wb_dat_w,
    output phy_mgmt_pkg::wb_data_t      wb_dat_r,
    output logic                        wb_ack,
    // MDIO master
    output logic                        cmd_start,
    output phy_mgmt_pkg::mdio_cmd_t     cmd_word,
    input  logic                        busy,
    input  phy_mgmt_pkg::mdio_data_t    rd_data,
    input  phy_mgmt_pkg::phy_reg_addr_t rd_reg,
    // Receive capture
    output logic                        cap_restart,
    output logic [$clog2(RX_DEPTH)-1:0] buf_addr,
    input  phy_mgmt_pkg::rx_byte_t      buf_byte,
    input  logic [$clog2(RX_DEPTH)-1:0] cap_count
);

    localparam int AW = $clog2(RX_DEPTH);

    logic                   access;   // New cycle, ack not yet given
    phy_mgmt_pkg::wb_data_t rd_mux;

    assign access   = wb_cyc && wb_stb && !wb_ack;
    assign buf_addr = wb_adr[AW-1:0];   // Upper buffer addresses alias

    // ------------------------------------------------------------
    // Read data select
    // ------------------------------------------------------------
    always_comb begin
        rd_mux = '0;                                       // Unused addresses read zero
        if (!wb_adr[7])
            rd_mux[7:0] = buf_byte;
        else if (wb_adr == phy_mgmt_pkg::ADDR_MDIO_CMD)
            rd_mux = {busy, 10'd0, rd_reg, rd_data};
        else if (wb_adr == phy_mgmt_pkg::ADDR_RX_RESTART)
            rd_mux[AW-1:0] = cap_count;
    end

    // ------------------------------------------------------------
    // Ack and command strobes
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            cmd_start   <= 1'b0;
            cap_restart <= 1'b0;
        end else begin
            wb_ack      <= access;                         // Single-cycle ack
            cmd_start   <= access && wb_we && (wb_adr == phy_mgmt_pkg::ADDR_MDIO_CMD);
            cap_restart <= access && wb_we && (wb_adr == phy_mgmt_pkg::ADDR_RX_RESTART);
        end
    end

    // Read data and command word, both valid together with ack
    always_ff @(posedge RxClk) begin
        if (access) begin
            wb_dat_r <= rd_mux;
            cmd_word <= wb_dat_w;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_capture #(
    parameter int RX_DEPTH = 64                          // Buffer bytes, power of two
) (
    input  logic                             RxClk,
    input  logic                             rst,
    input  logic                             rx_valid,
    input  phy_mgmt_pkg::rx_nibble_t         rx_data,
    input  logic                             cap_restart,  // One-cycle restart pulse
    input  logic [$clog2(RX_DEPTH)-1:0]      buf_addr,
    output phy_mgmt_pkg::rx_byte_t           buf_byte,
    output logic [$clog2(RX_DEPTH)-1:0]      cap_count
);

    localparam int AW = $clog2(RX_DEPTH);

    localparam logic [AW-1:0] PTR_STOP = AW'(RX_DEPTH - 1);  // Last location stays unused

    phy_mgmt_pkg::rx_byte_t     rx_mem [RX_DEPTH];
    logic [AW-1:0]              wr_ptr;
    logic                       hi_phase;   // Next nibble is the high half
    phy_mgmt_pkg::rx_nibble_t   lo_nibble;  // First nibble of the byte
    logic                       take;
    logic                       byte_we;

    // Nibbles count only while there is room and no restart
    assign take    = rx_valid && (wr_ptr != PTR_STOP) && !cap_restart;
    assign byte_we = take && hi_phase;

    // ------------------------------------------------------------
    // Nibble phase and write pointer
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst || cap_restart) begin
            wr_ptr   <= '0;
            hi_phase <= 1'b0;
        end else if (take) begin
            hi_phase <= ~hi_phase;
            if (hi_phase)
                wr_ptr <= wr_ptr + AW'(1);    // Byte complete
        end
    end

    // Low nibble holding register
    always_ff @(posedge RxClk) begin
        if (take && !hi_phase)
            lo_nibble <= rx_data;
    end

    // ------------------------------------------------------------
    // Capture buffer
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (byte_we)
            rx_mem[wr_ptr] <= {rx_data, lo_nibble};  // High nibble arrives second
    end

    assign buf_byte  = rx_mem[buf_addr];  // Asynchronous read port
    assign cap_count = wr_ptr;            // Bytes stored so far

endmodule

`default_nettype wire

// ==== verif/phy_iface_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module phy_iface_chk (
    input logic                    RxClk,
    input logic                    rst,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input logic                    mdc,
    input logic                    mdio_oe,
    input logic                    busy,
    input logic                    cmd_start,
    input phy_mgmt_pkg::mdio_cmd_t cmd_word
);

    int unsigned fail_cnt = 0;       // Read by the testbench at the end
    logic        mdc_q;
    logic [6:0]  edge_cnt;           // MDC rising edges seen in this frame
    logic        rd_frame;           // Frame in flight is a read
    logic        mdc_rise;

    assign mdc_rise = mdc && !mdc_q;

    // ----------------------------------------------------------
    // Frame tracking
    // ----------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (rst) begin
            mdc_q    <= 1'b0;
            edge_cnt <= '0;
            rd_frame <= 1'b0;
        end else begin
            mdc_q <= mdc;
            if (!busy)
                edge_cnt <= '0;
            else if (mdc_rise)
                edge_cnt <= edge_cnt + 7'd1;
            if (cmd_start && !busy)    // Accepted command only
                rd_frame <= (cmd_word[phy_mgmt_pkg::OP_LSB +: 2] == phy_mgmt_pkg::OP_READ);
        end
    end

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    reset_idle: assert property (@(posedge RxClk) rst |=> (!mdc && !mdio_oe && !busy))
        else begin $error("MDIO master not idle after reset"); fail_cnt++; end

    ack_after_stb: assert property (@(posedge RxClk) disable iff (rst)
        wb_cyc && $rose(wb_stb) |=> wb_ack)
        else begin $error("wb_ack missing one cycle after stb"); fail_cnt++; end

    ack_single: assert property (@(posedge RxClk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin $error("wb_ack held longer than one cycle"); fail_cnt++; end

    ack_needs_stb: assert property (@(posedge RxClk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin $error("wb_ack without a request"); fail_cnt++; end

    busy_on_start: assert property (@(posedge RxClk) disable iff (rst)
        cmd_start && !busy |=> busy)
        else begin $error("busy did not rise after cmd_start"); fail_cnt++; end

    // TA bits are frame edges 46 and 47 (32 preamble plus 14 command bits)
    ta_released: assert property (@(posedge RxClk) disable iff (rst)
        busy && rd_frame && mdc_rise && (edge_cnt == 7'd46 || edge_cnt == 7'd47) |-> !mdio_oe)
        else begin $error("mdio driven during read turnaround"); fail_cnt++; end

    write_drives: assert property (@(posedge RxClk) disable iff (rst)
        busy && !rd_frame |-> mdio_oe)
        else begin $error("mdio released inside a write frame"); fail_cnt++; end

    idle_released: assert property (@(posedge RxClk) disable iff (rst) !busy |-> !mdio_oe)
        else begin $error("mdio driven while idle"); fail_cnt++; end

endmodule

bind phy_iface_top phy_iface_chk phy_iface_chk_inst (
    .RxClk     (RxClk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .mdc       (mdc),
    .mdio_oe   (mdio_oe),
    .busy      (busy),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word)
);

`default_nettype wire

// ==== verif/phy_iface_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module phy_iface_tb;

    localparam int MDC_HALF     = 8;
    localparam int RX_DEPTH     = 64;
    localparam int FRAME_CYC    = 64 * 2 * MDC_HALF;   // One MDIO frame in clocks
    localparam int WATCHDOG_CYC = 8 * FRAME_CYC + 2000;
    localparam int ACK_LIMIT    = 16;                  // Clocks to wait for wb_ack
    localparam int POLL_LIMIT   = FRAME_CYC;           // Status reads before giving up

    logic                        RxClk;
    logic                        rst;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    phy_mgmt_pkg::wb_addr_t      wb_adr;
    phy_mgmt_pkg::wb_data_t      wb_dat_w;
    phy_mgmt_pkg::wb_data_t      wb_dat_r;
    logic                        wb_ack;
    logic                        mdc;
    wire                         mdio;
    logic                        phy_rst_n;
    logic                        rx_valid;
    phy_mgmt_pkg::rx_nibble_t    rx_data;

    int                          errors;
    logic [31:0]                 lfsr_state;
    phy_mgmt_pkg::rx_byte_t      exp_bytes[$];     // Bytes the buffer should hold

    // PHY model state
    logic                        phy_oe = 1'b0;
    logic                        phy_out = 1'b0;
    logic                        in_frame = 1'b0;
    logic                        is_read = 1'b0;
    int                          ones_run = 0;
    int                          n_bits = 0;
    int                          frame_cnt = 0;    // Complete frames seen
    phy_mgmt_pkg::mdio_cmd_t     frame_word;
    phy_mgmt_pkg::mdio_cmd_t     last_frame;
    phy_mgmt_pkg::mdio_data_t    reply;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) tb_clk_gen_inst (.RxClk(RxClk), .rst(rst));

    phy_iface_top #(
        .MDC_HALF (MDC_HALF),
        .RX_DEPTH (RX_DEPTH)
    ) phy_iface_top_inst (
        .RxClk    (RxClk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .mdc      (mdc),
        .mdio     (mdio),
        .phy_rst_n(phy_rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    pullup (mdio);                                  // Idle line reads one
    assign mdio = phy_oe ? phy_out : 1'bz;

    // Register contents the PHY model answers with
    function automatic phy_mgmt_pkg::mdio_data_t phy_reg_value(input phy_mgmt_pkg::phy_reg_addr_t a);
        return {3'b101, a, ~a, 3'b011};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit, first bit lands in the MSB
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ----------------------------------------------------------
    // PHY model, counts MDC rising edges after 32 ones
    // ----------------------------------------------------------
    always @(posedge mdc) begin
        if (!in_frame) begin
            if (mdio === 1'b0 && ones_run >= 32) begin
                in_frame   = 1'b1;               // ST first bit already seen
                frame_word = '0;
                n_bits     = 1;
            end
            ones_run = (mdio === 1'b1) ? ones_run + 1 : 0;
        end else begin
            frame_word[31 - n_bits] = mdio;
            n_bits++;
            if (n_bits == 16) begin              // Command and TA bits received
                is_read = (frame_word[29:28] == phy_mgmt_pkg::OP_READ);
                reply   = phy_reg_value(frame_word[22:18]);
            end
            if (n_bits == 32) begin
                last_frame = frame_word;
                frame_cnt++;
                in_frame = 1'b0;
                is_read  = 1'b0;
                ones_run = 0;
            end
        end
    end

    always @(negedge mdc) begin
        phy_oe = in_frame && is_read && n_bits >= 16;   // Own the line after TA
        if (phy_oe)
            phy_out = reply[31 - n_bits];
    end

    // ----------------------------------------------------------
    // Wishbone driver
    // ----------------------------------------------------------
    task automatic wb_access(input logic we, input phy_mgmt_pkg::wb_addr_t adr,
                             input phy_mgmt_pkg::wb_data_t wdata,
                             output phy_mgmt_pkg::wb_data_t rdata);
        int waited;
        @(negedge RxClk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(negedge RxClk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            $display("Wishbone access to address %h got no ack", adr);
            errors++;
        end
        rdata  = wb_dat_r;                       // Stable between rising edges
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input phy_mgmt_pkg::wb_addr_t adr, input phy_mgmt_pkg::wb_data_t d);
        phy_mgmt_pkg::wb_data_t unused;
        wb_access(1'b1, adr, d, unused);
    endtask

    task automatic wb_read(input phy_mgmt_pkg::wb_addr_t adr, output phy_mgmt_pkg::wb_data_t d);
        wb_access(1'b0, adr, '0, d);
    endtask

    // Poll the busy bit, returns the last status word
    task automatic wait_mdio_idle(output phy_mgmt_pkg::wb_data_t status);
        int polls;
        polls = 0;
        do begin
            wb_read(phy_mgmt_pkg::ADDR_MDIO_CMD, status);
            polls++;
        end while (status[31] && polls < POLL_LIMIT);
        if (status[31]) begin
            $display("MDIO busy bit never cleared");
            errors++;
        end
    endtask

    // ----------------------------------------------------------
    // MDIO command tests
    // ----------------------------------------------------------
    task automatic run_mdio_cmd(input logic rd_op, input logic overlap);
        logic [31:0]             r;
        phy_mgmt_pkg::mdio_cmd_t cmd;
        phy_mgmt_pkg::wb_data_t  status;
        phy_mgmt_pkg::wb_data_t  exp_status;
        int                      frames_before;
        take_bits(26, r);                                  // PHYAD, REGAD, DATA
        cmd = {2'b01, rd_op ? 2'b10 : 2'b01, r[25:16], 2'b10, r[15:0]};
        frames_before = frame_cnt;
        wb_write(phy_mgmt_pkg::ADDR_MDIO_CMD, cmd);
        if (overlap)
            wb_write(phy_mgmt_pkg::ADDR_MDIO_CMD, ~cmd);   // Arrives while busy
        wait_mdio_idle(status);
        assert (frame_cnt == frames_before + 1) else begin
            $display("PHY model saw %0d frames instead of one", frame_cnt - frames_before);
            errors++;
        end
        if (rd_op) begin
            exp_status = {1'b0, 10'd0, r[20:16], phy_reg_value(r[20:16])};
            assert (status == exp_status) else begin
                $display("Error: wb_dat_r got %h expected %h", status, exp_status);
                errors++;
            end
            assert (last_frame[31:18] == cmd[31:18]) else begin
                $display("Error: cmd_word got %h expected %h", last_frame[31:18], cmd[31:18]);
                errors++;
            end
        end else begin
            assert (last_frame == cmd) else begin
                $display("Error: cmd_word got %h expected %h", last_frame, cmd);
                errors++;
            end
        end
    endtask

    // ----------------------------------------------------------
    // MII nibble source and buffer check
    // ----------------------------------------------------------
    task automatic send_nibble(input phy_mgmt_pkg::rx_nibble_t nib);
        logic [31:0] gap;
        take_bits(1, gap);
        if (gap[0]) begin                        // Idle cycle between nibbles
            rx_valid = 1'b0;
            @(negedge RxClk);
        end
        rx_valid = 1'b1;
        rx_data  = nib;
        @(negedge RxClk);
    endtask

    task automatic feed_bytes(input int n);
        logic [31:0] v;
        int          i;
        for (i = 0; i < n; i++) begin
            take_bits(8, v);
            send_nibble(v[3:0]);                 // Low nibble first
            send_nibble(v[7:4]);
            if (exp_bytes.size() < RX_DEPTH - 1)
                exp_bytes.push_back(v[7:0]);
        end
        rx_valid = 1'b0;
    endtask

    task automatic check_capture();
        phy_mgmt_pkg::wb_data_t rd;
        wb_read(phy_mgmt_pkg::ADDR_RX_RESTART, rd);
        assert (rd == 32'(exp_bytes.size())) else begin
            $display("Error: cap_count got %h expected %h", rd, exp_bytes.size());
            errors++;
        end
        foreach (exp_bytes[i]) begin
            wb_read(phy_mgmt_pkg::wb_addr_t'(i), rd);
            assert (rd == {24'd0, exp_bytes[i]}) else begin
                $display("Error: buf_byte[%0d] got %h expected %h", i, rd, exp_bytes[i]);
                errors++;
            end
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main_seq
        phy_mgmt_pkg::wb_data_t rd;
        int                     chk_fails;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        rx_valid   = 1'b0;
        rx_data    = '0;
        errors     = 0;
        lfsr_state = 32'h5de9_dee0;
        @(negedge rst);
        assert (mdc === 1'b0) else begin
            $display("Error: mdc got %h expected %h", mdc, 1'b0);
            errors++;
        end
        assert (mdio === 1'b1) else begin        // Released line held up by the pullup
            $display("Error: mdio got %h expected %h", mdio, 1'b1);
            errors++;
        end
        assert (phy_rst_n === 1'b1) else begin
            $display("Error: phy_rst_n got %h expected %h", phy_rst_n, 1'b1);
            errors++;
        end
        wb_read(phy_mgmt_pkg::ADDR_MDIO_CMD, rd);
        assert (rd == '0) else begin
            $display("Error: wb_dat_r got %h expected %h", rd, 32'h0);
            errors++;
        end
        run_mdio_cmd(1'b0, 1'b0);                // Two writes, two reads
        run_mdio_cmd(1'b0, 1'b0);
        run_mdio_cmd(1'b1, 1'b0);
        run_mdio_cmd(1'b1, 1'b0);
        run_mdio_cmd(1'b0, 1'b1);                // Second command dropped
        feed_bytes(10);
        check_capture();
        feed_bytes(60);                          // Runs past the stop point
        check_capture();
        wb_write(phy_mgmt_pkg::ADDR_RX_RESTART, '0);
        exp_bytes.delete();
        check_capture();
        feed_bytes(3);
        check_capture();
        repeat (4) @(posedge RxClk);             // Let pending assertions finish
        chk_fails = phy_iface_top_inst.phy_iface_chk_inst.fail_cnt;
        $display("Done with %0d testbench errors and %0d assertion failures", errors, chk_fails);
        if (errors == 0 && chk_fails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYC) @(posedge RxClk);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,        // RxClk period
    parameter int RST_CYCLES = 2          // Rising edges with rst high
) (
    output logic RxClk,
    output logic rst
);

    initial begin
        RxClk = 1'b0;
        forever #(PERIOD_NS / 2) RxClk = ~RxClk;
    end

    // Reset released on a falling edge, like every other DUT input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge RxClk);
        @(negedge RxClk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/phy_mgmt_pkg.sv
hdl/mdio_master.sv
hdl/rx_capture.sv
hdl/phy_reg_slave.sv
hdl/phy_iface_top.sv
verif/tb_clk_gen.sv
verif/phy_iface_chk.sv
verif/phy_iface_tb.sv
